// ==== common/observer_pkg.sv ====
// Shared definitions for the I3C bus observer
// Timing and counter widths, frame kinds, header/CCC byte views, CCC codes

package observer_pkg;

  localparam int unsigned TimingWidth   = 20; // Hold-time config width
  localparam int unsigned DetCountWidth = 14; // START/STOP hold counter
  localparam int unsigned CountWidth    = 8;  // Saturating event counters

  localparam logic [6:0] BroadcastAddr = 7'h7E; // I3C broadcast address
  localparam logic [7:0] CccEntHdr0    = 8'h20; // ENTHDR0 broadcast CCC

  // Kind of a received SDR byte
  typedef enum logic [1:0] {
    FRAME_HEADER = 2'd0, // Address header after START
    FRAME_CCC    = 2'd1, // Byte after a broadcast write header
    FRAME_DATA   = 2'd2
  } frame_kind_e;

  // Address header view, MSB first on the wire
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;  // 1 = read
  } addr_frame_t;

  // CCC view
  typedef struct packed {
    logic       direct; // Set for direct CCCs
    logic [6:0] code;
  } ccc_frame_t;

  // One received byte, decoded as header or CCC
  typedef union packed {
    addr_frame_t hdr;
    ccc_frame_t  ccc;
  } frame_byte_u;

endpackage

// ==== rtl/bus_sync.sv ====
// Two-flop synchronizers for the SCL and SDA pins
// Flops reset to the idle-high bus level

`timescale 1ns/1ps

module bus_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i, // Raw bus SCL
  input  logic sda_i, // Raw bus SDA
  output logic scl_o, // Synchronized, 2 cycles late
  output logic sda_o
);

  logic [1:0] scl_q; // [0] first stage, [1] second stage
  logic [1:0] sda_q;

  // Idle-high reset so leaving reset never looks like a START
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 2'b11;
      sda_q <= 2'b11;
    end else begin
      scl_q <= {scl_q[0], scl_i};
      sda_q <= {sda_q[0], sda_i};
    end
  end

  assign scl_o = scl_q[1];
  assign sda_o = sda_q[1];

endmodule

// ==== bus_monitor/bus_monitor.sv ====
// Bus condition detector for the observer
// START / repeated START and STOP with data hold qualification
// HDR exit pattern detection (four SDA falls with SCL low, then STOP)

`timescale 1ns/1ps

module bus_monitor (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 enable_i,
  input  logic                                 scl_i,       // Synchronized SCL
  input  logic                                 sda_i,       // Synchronized SDA
  input  logic [observer_pkg::TimingWidth-1:0] t_hd_dat_i,  // Hold time in cycles, >= 1
  input  logic                                 hdr_mode_i,
  output logic                                 start_detect_o,
  output logic                                 stop_detect_o,
  output logic                                 hdr_exit_detect_o
);

  logic scl_q, sda_q;                // Previous sample
  logic sda_fall, sda_rise;
  logic scl_hi_stable, scl_lo_stable;
  logic sda_hi_stable;

  logic start_trig, stop_trig;
  logic start_pend, stop_pend;
  logic hold_met;
  logic [observer_pkg::DetCountWidth-1:0] det_cnt; // Shared START/STOP hold counter

  logic       exit_trig;
  logic       exit_armed;
  logic [4:0] exit_shift; // One-hot, walks right on each SDA fall

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1; // Idle bus
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  // Edges and stable levels against the previous sample
  assign sda_fall      = sda_q & ~sda_i;
  assign sda_rise      = ~sda_q & sda_i;
  assign scl_hi_stable = scl_q & scl_i;
  assign scl_lo_stable = ~(scl_q | scl_i);
  assign sda_hi_stable = sda_q & sda_i;

  assign start_trig = enable_i & scl_hi_stable & sda_fall; // SDA falls, SCL high
  assign stop_trig  = enable_i & scl_hi_stable & sda_rise; // SDA rises, SCL high

  // Count 1 in the cycle after the trigger, so the pulse lands t_hd_dat_i cycles later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      det_cnt <= '0;
    end else if (start_trig || stop_trig) begin
      det_cnt <= observer_pkg::DetCountWidth'(1);
    end else if (start_pend || stop_pend) begin
      det_cnt <= det_cnt + 1'b1;
    end
  end

  assign hold_met = det_cnt >= t_hd_dat_i[observer_pkg::DetCountWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pend <= 1'b0;
      stop_pend  <= 1'b0;
    end else begin
      // SCL low, disable or the opposite trigger cancel a pending condition
      if (start_trig) start_pend <= 1'b1;
      else if (!enable_i || !scl_i || start_detect_o || stop_trig) start_pend <= 1'b0;
      if (stop_trig) stop_pend <= 1'b1;
      else if (!enable_i || !scl_i || stop_detect_o || start_trig) stop_pend <= 1'b0;
    end
  end

  assign start_detect_o = enable_i & start_pend & hold_met;
  assign stop_detect_o  = enable_i & stop_pend & hold_met;

  // HDR exit arms on SCL low with SDA high while in HDR mode
  assign exit_trig = enable_i & hdr_mode_i & scl_lo_stable & sda_hi_stable;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_armed <= 1'b0;
      exit_shift <= 5'b10000;
    end else if (exit_trig) begin
      exit_armed <= 1'b1;
    end else if (!enable_i || stop_detect_o) begin
      exit_armed <= 1'b0;                       // Pattern consumed or aborted
      exit_shift <= 5'b10000;
    end else if (exit_armed && sda_fall) begin
      exit_shift <= {1'b0, exit_shift[4:1]};    // Bit 0 set after four falls
    end
  end

  // Exit reported together with the closing STOP
  assign hdr_exit_detect_o = exit_shift[0] & stop_detect_o;

  // The hold counter is shared, so both conditions can never qualify together
  a_start_stop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_detect_o && stop_detect_o));

endmodule

// ==== frame_rx/frame_rx.sv ====
// SDR frame receiver
// Shifts in 9-bit frames on SCL rising edges after each START
// Classifies bytes as address header, broadcast CCC or data

`timescale 1ns/1ps

module frame_rx (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      scl_i,        // Synchronized SCL
  input  logic                      sda_i,        // Synchronized SDA
  input  logic                      start_det_i,
  input  logic                      stop_det_i,
  input  logic                      hdr_mode_i,
  output logic                      byte_valid_o, // One cycle after the ninth edge
  output observer_pkg::frame_byte_u frame_byte_o,
  output observer_pkg::frame_kind_e frame_kind_o,
  output logic                      ninth_bit_o   // ACK/T bit of the frame
);

  logic                      scl_q;
  logic                      scl_rise;
  logic                      active_q;  // Inside an SDR transfer
  logic                      sample;
  logic                      ninth;
  logic [3:0]                bit_cnt_q; // 0..8 within a frame
  logic [7:0]                shift_q;
  observer_pkg::frame_kind_e kind_q;    // Kind of the byte being received
  logic                      bcast_wr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) scl_q <= 1'b1;
    else         scl_q <= scl_i;
  end

  assign scl_rise = ~scl_q & scl_i;
  assign sample   = scl_rise & active_q & ~hdr_mode_i; // No SDR sampling in HDR
  assign ninth    = sample & (bit_cnt_q == 4'd8);

  assign frame_byte_o = shift_q; // Full byte stays put until the next frame
  // Header 0x7E with write turns the next byte into a CCC
  assign bcast_wr = (frame_byte_o.hdr.addr == observer_pkg::BroadcastAddr) &
                    ~frame_byte_o.hdr.rnw;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q     <= 1'b0;
      bit_cnt_q    <= '0;
      kind_q       <= observer_pkg::FRAME_HEADER;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= ninth;
      if (hdr_mode_i || stop_det_i) begin
        active_q  <= 1'b0; // Idle until the next START
        bit_cnt_q <= '0;
      end else if (start_det_i) begin
        active_q  <= 1'b1;
        bit_cnt_q <= '0;
        kind_q    <= observer_pkg::FRAME_HEADER; // First byte after (r)START
      end else if (ninth) begin
        bit_cnt_q <= '0;
        if (kind_q == observer_pkg::FRAME_HEADER && bcast_wr) begin
          kind_q <= observer_pkg::FRAME_CCC;
        end else begin
          kind_q <= observer_pkg::FRAME_DATA;
        end
      end else if (sample) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge clk_i) begin
    if (sample && !ninth) shift_q <= {shift_q[6:0], sda_i}; // MSB first
    if (ninth) begin
      ninth_bit_o  <= sda_i;
      frame_kind_o <= kind_q;
    end
  end

  // HDR mode is set only after a byte_valid, and blocks further SDR bytes
  a_no_byte_in_hdr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_valid_o |-> !hdr_mode_i);

endmodule

// ==== rtl/event_log.sv ====
// Event log of the bus observer
// Saturating condition counters, last header and CCC, HDR mode state

`timescale 1ns/1ps

module event_log (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                start_det_i,
  input  logic                                stop_det_i,
  input  logic                                hdr_exit_det_i,
  input  logic                                byte_valid_i,
  input  observer_pkg::frame_byte_u           frame_byte_i,
  input  observer_pkg::frame_kind_e           frame_kind_i,
  input  logic                                ninth_bit_i,
  output logic [observer_pkg::CountWidth-1:0] start_count_o,
  output logic [observer_pkg::CountWidth-1:0] stop_count_o,
  output logic [observer_pkg::CountWidth-1:0] hdr_exit_count_o,
  output logic [6:0]                          last_addr_o,
  output logic                                last_rnw_o,
  output logic                                last_ack_o,  // 1 = header was ACKed
  output logic [7:0]                          last_ccc_o,
  output logic                                hdr_mode_o
);

  logic hdr_byte, ccc_byte;

  // Increment that sticks at all ones
  function automatic logic [observer_pkg::CountWidth-1:0] sat_inc(
    input logic [observer_pkg::CountWidth-1:0] val
  );
    return (&val) ? val : val + 1'b1;
  endfunction

  assign hdr_byte = byte_valid_i & (frame_kind_i == observer_pkg::FRAME_HEADER);
  assign ccc_byte = byte_valid_i & (frame_kind_i == observer_pkg::FRAME_CCC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_count_o    <= '0;
      stop_count_o     <= '0;
      hdr_exit_count_o <= '0;
      last_addr_o      <= '0;
      last_rnw_o       <= 1'b0;
      last_ack_o       <= 1'b0;
      last_ccc_o       <= '0;
      hdr_mode_o       <= 1'b0;
    end else begin
      if (start_det_i)    start_count_o    <= sat_inc(start_count_o);
      if (stop_det_i)     stop_count_o     <= sat_inc(stop_count_o);
      if (hdr_exit_det_i) hdr_exit_count_o <= sat_inc(hdr_exit_count_o);
      if (hdr_byte) begin
        last_addr_o <= frame_byte_i.hdr.addr; // Address view
        last_rnw_o  <= frame_byte_i.hdr.rnw;
        last_ack_o  <= ~ninth_bit_i;          // Low ninth bit is ACK
      end
      if (ccc_byte) last_ccc_o <= frame_byte_i.ccc; // CCC view
      // ENTHDR0 enters HDR, the monitor's exit pattern leaves it
      if (ccc_byte && frame_byte_i.ccc == observer_pkg::CccEntHdr0) hdr_mode_o <= 1'b1;
      else if (hdr_exit_det_i) hdr_mode_o <= 1'b0;
    end
  end

  // Exit detection relies on the fed-back HDR mode in the monitor
  a_exit_in_hdr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hdr_exit_det_i |-> hdr_mode_o);

endmodule

// ==== rtl/i3c_bus_observer.sv ====
// Passive I3C bus observer top level
// Synchronizer and monitor, frame receiver, event log

`timescale 1ns/1ps

module i3c_bus_observer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 enable_i,
  input  logic                                 scl_i,
  input  logic                                 sda_i,
  input  logic [observer_pkg::TimingWidth-1:0] t_hd_dat_i, // Static, >= 1
  output logic [observer_pkg::CountWidth-1:0]  start_count_o,
  output logic [observer_pkg::CountWidth-1:0]  stop_count_o,
  output logic [observer_pkg::CountWidth-1:0]  hdr_exit_count_o,
  output logic [6:0]                           last_addr_o,
  output logic                                 last_rnw_o,
  output logic                                 last_ack_o,
  output logic [7:0]                           last_ccc_o,
  output logic                                 hdr_mode_o
);

  logic scl_s, sda_s;                     // Synchronized bus lines
  logic start_det, stop_det, hdr_exit_det;
  logic byte_valid, ninth_bit;
  observer_pkg::frame_byte_u frame_byte;
  observer_pkg::frame_kind_e frame_kind;

  bus_sync u_bus_sync (
    .clk_i, .rst_ni, .scl_i, .sda_i, .scl_o(scl_s), .sda_o(sda_s)
  );

  bus_monitor u_bus_monitor (
    .clk_i, .rst_ni, .enable_i, .scl_i(scl_s), .sda_i(sda_s), .t_hd_dat_i,
    .hdr_mode_i(hdr_mode_o), // HDR state fed back from the log
    .start_detect_o(start_det), .stop_detect_o(stop_det), .hdr_exit_detect_o(hdr_exit_det)
  );

  frame_rx u_frame_rx (
    .clk_i, .rst_ni, .scl_i(scl_s), .sda_i(sda_s), .start_det_i(start_det),
    .stop_det_i(stop_det), .hdr_mode_i(hdr_mode_o), .byte_valid_o(byte_valid),
    .frame_byte_o(frame_byte), .frame_kind_o(frame_kind), .ninth_bit_o(ninth_bit)
  );

  event_log u_event_log (
    .clk_i, .rst_ni, .start_det_i(start_det), .stop_det_i(stop_det),
    .hdr_exit_det_i(hdr_exit_det), .byte_valid_i(byte_valid), .frame_byte_i(frame_byte),
    .frame_kind_i(frame_kind), .ninth_bit_i(ninth_bit), .start_count_o, .stop_count_o,
    .hdr_exit_count_o, .last_addr_o, .last_rnw_o, .last_ack_o, .last_ccc_o, .hdr_mode_o
  );

endmodule

// ==== tests/tb_clk.sv ====
// Testbench clock and reset generator
// 20 ns clock, active-low reset held for 5 cycles

`timescale 1ns/1ps

module tb_clk (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriodNs = 10;
  localparam int ResetCycles  = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1; // Released on a rising edge
  end

endmodule

// ==== tests/tb_observer.sv ====
// Directed testbench for the I3C bus observer
// Bus phase drivers, LFSR stimulus, compare tasks, watchdog

`timescale 1ns/1ps

module tb_observer;

  localparam int HoldCycles  = 3;
  localparam int PhaseCycles = HoldCycles + 4; // One bus phase
  localparam int NumTests    = 6;
  localparam int LimitCycles = NumTests * 400 * PhaseCycles; // 400 phases per test

  logic clk, rst_n, enable, scl, sda;
  logic [observer_pkg::TimingWidth-1:0] t_hd_dat;
  logic [observer_pkg::CountWidth-1:0]  start_count, stop_count, hdr_exit_count;
  logic [6:0]  last_addr;
  logic        last_rnw, last_ack, hdr_mode;
  logic [7:0]  last_ccc;
  logic [15:0] lfsr_q;
  int          starts, stops, exits; // Conditions put on the bus so far

  tb_clk u_clk (.clk_o(clk), .rst_no(rst_n));

  i3c_bus_observer UUT (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable), .scl_i(scl), .sda_i(sda),
    .t_hd_dat_i(t_hd_dat), .start_count_o(start_count), .stop_count_o(stop_count),
    .hdr_exit_count_o(hdr_exit_count), .last_addr_o(last_addr), .last_rnw_o(last_rnw),
    .last_ack_o(last_ack), .last_ccc_o(last_ccc), .hdr_mode_o(hdr_mode)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_count(input string name, input logic [observer_pkg::CountWidth-1:0] exp,
                             input logic [observer_pkg::CountWidth-1:0] act);
    if (act !== exp) fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_addr(input string name, input observer_pkg::addr_frame_t exp,
                            input observer_pkg::addr_frame_t act);
    if (act !== exp) fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_ccc(input string name, input observer_pkg::ccc_frame_t exp,
                           input observer_pkg::ccc_frame_t act);
    if (act !== exp) fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q); // One step per bit
      val    = {val[6:0], lfsr_q[15]};
    end
  endtask

  // Counters stick at the top value
  function automatic logic [observer_pkg::CountWidth-1:0] capped(input int total);
    return (total > 255) ? 8'd255 : observer_pkg::CountWidth'(total);
  endfunction

  task automatic bus_phase(input logic scl_v, input logic sda_v);
    @(posedge clk);
    scl <= scl_v;
    sda <= sda_v;
    repeat (PhaseCycles - 1) @(posedge clk);
  endtask

  task automatic bus_start(); // SDA falls under high SCL, bus must be idle
    bus_phase(1'b1, 1'b0);
    bus_phase(1'b0, 1'b0);
    if (enable) starts++;
  endtask

  task automatic bus_rstart(); // From SCL low back to idle, then START
    bus_phase(1'b0, 1'b1);
    bus_phase(1'b1, 1'b1);
    bus_start();
  endtask

  task automatic bus_stop();
    bus_phase(1'b0, 1'b0);
    bus_phase(1'b1, 1'b0);
    bus_phase(1'b1, 1'b1); // SDA rises under high SCL
    if (enable) stops++;
  endtask

  task automatic bus_byte(input logic [7:0] data, input logic ninth);
    logic [8:0] frame;
    frame = {data, ninth}; // MSB first, ninth bit last
    for (int i = 8; i >= 0; i--) begin
      bus_phase(1'b0, frame[i]); // SDA only moves while SCL is low
      bus_phase(1'b1, frame[i]);
      bus_phase(1'b0, frame[i]);
    end
  endtask

  task automatic check_events(input string name);
    repeat (PhaseCycles) @(posedge clk); // Detector and log latency
    @(negedge clk);
    check_count({name, " starts"}, capped(starts), start_count);
    check_count({name, " stops"}, capped(stops), stop_count);
    check_count({name, " exits"}, capped(exits), hdr_exit_count);
  endtask

  task automatic test_reset();
    check_events("reset");
    check_flag("reset hdr_mode", 1'b0, hdr_mode);
    check_flag("reset last_ack", 1'b0, last_ack);
    check_addr("reset last_addr", '0, {last_addr, last_rnw});
    check_ccc("reset last_ccc", '0, last_ccc);
  endtask

  task automatic test_start_stop();
    bus_start();
    bus_stop();
    check_events("start stop");
    bus_start();
    bus_rstart();
    bus_stop();
    check_events("repeated start");
    @(posedge clk);
    sda <= 1'b0;
    @(posedge clk);
    scl <= 1'b0; // SCL drops well inside the hold time
    bus_phase(1'b0, 1'b1);
    bus_phase(1'b1, 1'b1);
    check_events("short start");
    @(posedge clk);
    enable <= 1'b0;
    bus_start();
    bus_stop();
    @(posedge clk);
    enable <= 1'b1;
    check_events("disabled");
  endtask

  task automatic test_private_header();
    logic [7:0] hdr, ninth;
    take_bits(8, hdr);   // Address and rnw
    take_bits(1, ninth);
    bus_start();
    bus_byte(hdr, ninth[0]);
    bus_stop();
    check_events("private header");
    check_addr("private header", hdr, {last_addr, last_rnw});
    check_flag("private header ack", ~ninth[0], last_ack); // Low ninth bit is ACK
  endtask

  task automatic test_broadcast_ccc();
    logic [7:0] ccc, data;
    take_bits(8, ccc);
    if (ccc == observer_pkg::CccEntHdr0) ccc = ~ccc; // Stay in SDR here
    bus_start();
    bus_byte({observer_pkg::BroadcastAddr, 1'b0}, 1'b0);
    bus_byte(ccc, 1'b0);
    for (int i = 0; i < 2; i++) begin
      take_bits(8, data);
      bus_byte(data, 1'b1);
    end
    bus_stop();
    check_events("broadcast ccc");
    check_ccc("ccc after data", ccc, last_ccc);
    check_flag("ccc hdr_mode", 1'b0, hdr_mode);
  endtask

  task automatic test_hdr();
    bus_start();
    bus_byte({observer_pkg::BroadcastAddr, 1'b0}, 1'b0);
    bus_byte(observer_pkg::CccEntHdr0, 1'b0);
    check_events("hdr entry");
    check_flag("hdr entry", 1'b1, hdr_mode);
    bus_rstart();
    bus_byte(8'h55, 1'b0); // Five SDA falls, too many for an exit
    bus_stop();
    check_events("hdr frame");
    check_addr("hdr frame addr", {observer_pkg::BroadcastAddr, 1'b0}, {last_addr, last_rnw});
    check_flag("hdr frame mode", 1'b1, hdr_mode);
    bus_phase(1'b0, 1'b1); // Arms the exit detector
    for (int i = 0; i < 4; i++) begin
      bus_phase(1'b0, 1'b0);
      if (i < 3) bus_phase(1'b0, 1'b1);
    end
    bus_stop();
    exits++;
    check_events("hdr exit");
    check_flag("hdr exit mode", 1'b0, hdr_mode);
  endtask

  task automatic test_saturation();
    for (int i = 0; i < 260; i++) begin
      bus_start();
      bus_stop();
    end
    check_events("saturation");
    check_count("saturation start", 8'd255, start_count);
    check_count("saturation stop", 8'd255, stop_count);
  endtask

  initial begin
    enable   = 1'b1;
    scl      = 1'b1; // Idle bus
    sda      = 1'b1;
    t_hd_dat = HoldCycles;
    lfsr_q   = 16'd29600;
    starts   = 0;
    stops    = 0;
    exits    = 0;
    wait (rst_n === 1'b1);
    test_reset();
    test_start_stop();
    test_private_header();
    test_broadcast_ccc();
    test_hdr();
    test_saturation();
    $display("Testbench passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LimitCycles) @(posedge clk);
    fail_run($sformatf("timed out: tests did not finish within %0d cycles", LimitCycles));
  end

endmodule

// ==== list.f ====
common/observer_pkg.sv
rtl/bus_sync.sv
bus_monitor/bus_monitor.sv
frame_rx/frame_rx.sv
rtl/event_log.sv
rtl/i3c_bus_observer.sv
tests/tb_clk.sv
tests/tb_observer.sv

// ==== Bender.yml ====
package:
  name: i3c_bus_observer

sources:
  - common/observer_pkg.sv
  - rtl/bus_sync.sv
  - bus_monitor/bus_monitor.sv
  - frame_rx/frame_rx.sv
  - rtl/event_log.sv
  - rtl/i3c_bus_observer.sv
  - target: test
    files:
      - tests/tb_clk.sv
      - tests/tb_observer.sv
